/* hw/cp0_defines.svh */
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// CP0 register numbers, found in reg_addr[7:3]
`define CP0_INDEX_NUM    5'd0
`define CP0_ENTRYLO0_NUM 5'd2
`define CP0_ENTRYLO1_NUM 5'd3
`define CP0_BADVADDR_NUM 5'd8
`define CP0_COUNT_NUM    5'd9
`define CP0_ENTRYHI_NUM  5'd10
`define CP0_COMPARE_NUM  5'd11
`define CP0_STATUS_NUM   5'd12
`define CP0_CAUSE_NUM    5'd13
`define CP0_EPC_NUM      5'd14

// bit positions in the per-register strobe and select vectors
`define CP0_NREGS      10
`define CP0_R_INDEX    0
`define CP0_R_ENTRYLO0 1
`define CP0_R_ENTRYLO1 2
`define CP0_R_BADVADDR 3
`define CP0_R_COUNT    4
`define CP0_R_ENTRYHI  5
`define CP0_R_COMPARE  6
`define CP0_R_STATUS   7
`define CP0_R_CAUSE    8
`define CP0_R_EPC      9

`define CP0_TLB_NUM     16
// vpn2 19, asid 8, g 1, pfn0/c/d/v 25, pfn1/c/d/v 25
`define CP0_TLB_ENTRY_W 78

`endif

/* hw/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

	// privileged operation kind, OP_NONE is idle
	typedef enum logic [2:0] {
		OP_NONE  = 3'd0,
		OP_MFC0  = 3'd1,
		OP_MTC0  = 3'd2,
		OP_TLBP  = 3'd3,
		OP_TLBR  = 3'd4,
		OP_TLBWI = 3'd5,
		OP_ERET  = 3'd6,
		OP_EXC   = 3'd7
	} cp0_op_e;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_INT  = 5'h00,
		EXC_ADEL = 5'h04,
		EXC_ADES = 5'h05,
		EXC_SYS  = 5'h08,
		EXC_BP   = 5'h09,
		EXC_RI   = 5'h0a,
		EXC_OV   = 5'h0c
	} exc_code_e;

endpackage

`default_nettype wire

/* hw/cp0_op_decode.sv */
`default_nettype none

`include "cp0_defines.svh"

module cp0_op_decode (
	input  wire                   clk,
	input  wire                   rst,
	input  wire cp0_pkg::cp0_op_e op,
	input  wire [7:0]             reg_addr,
	input  wire [31:0]            wdata,
	input  wire [7:0]             exc_type,
	input  wire [31:0]            pc,
	input  wire                   is_slot,
	input  wire [31:0]            bad_vaddr,
	output logic [`CP0_NREGS-1:0] reg_wen,
	output logic [`CP0_NREGS-1:0] d_rsel,
	output logic [31:0]           d_wdata,
	output logic                  d_read,
	output logic                  d_tlbp,
	output logic                  d_tlbr,
	output logic                  d_tlbwi,
	output logic                  d_eret,
	output logic                  d_exc,
	output cp0_pkg::exc_code_e    d_exccode,
	output logic                  d_addr_err,
	output logic [31:0]           d_pc,
	output logic                  d_is_slot,
	output logic [31:0]           d_bad_vaddr
);

	logic [`CP0_NREGS-1:0] hit;
	cp0_pkg::exc_code_e    exc_code;
	logic                  addr_err;

	// only defined registers with select 0 get a strobe
	always_comb begin
		hit = '0;
		if (reg_addr[2:0] == 3'd0) begin
			case (reg_addr[7:3])
				`CP0_INDEX_NUM:    hit[`CP0_R_INDEX] = 1'b1;
				`CP0_ENTRYLO0_NUM: hit[`CP0_R_ENTRYLO0] = 1'b1;
				`CP0_ENTRYLO1_NUM: hit[`CP0_R_ENTRYLO1] = 1'b1;
				`CP0_BADVADDR_NUM: hit[`CP0_R_BADVADDR] = 1'b1;
				`CP0_COUNT_NUM:    hit[`CP0_R_COUNT] = 1'b1;
				`CP0_ENTRYHI_NUM:  hit[`CP0_R_ENTRYHI] = 1'b1;
				`CP0_COMPARE_NUM:  hit[`CP0_R_COMPARE] = 1'b1;
				`CP0_STATUS_NUM:   hit[`CP0_R_STATUS] = 1'b1;
				`CP0_CAUSE_NUM:    hit[`CP0_R_CAUSE] = 1'b1;
				`CP0_EPC_NUM:      hit[`CP0_R_EPC] = 1'b1;
				default:           hit = '0;
			endcase
		end
	end

	// flags are {int, fetch adel, load adel, store ades, sys, bp, ri, ov}
	always_comb begin
		addr_err = 1'b0;
		if (exc_type[7]) begin
			exc_code = cp0_pkg::EXC_INT;
		end else if (exc_type[6]) begin
			exc_code = cp0_pkg::EXC_ADEL;
			addr_err = 1'b1;
		end else if (exc_type[1]) begin
			exc_code = cp0_pkg::EXC_RI;
		end else if (exc_type[3]) begin
			exc_code = cp0_pkg::EXC_SYS;
		end else if (exc_type[2]) begin
			exc_code = cp0_pkg::EXC_BP;
		end else if (exc_type[0]) begin
			exc_code = cp0_pkg::EXC_OV;
		end else if (exc_type[5]) begin
			exc_code = cp0_pkg::EXC_ADEL;
			addr_err = 1'b1;
		end else begin
			exc_code = cp0_pkg::EXC_ADES;
			addr_err = exc_type[4];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_wen <= '0;
			d_rsel <= '0;
			d_read <= 1'b0;
			d_tlbp <= 1'b0;
			d_tlbr <= 1'b0;
			d_tlbwi <= 1'b0;
			d_eret <= 1'b0;
			d_exc <= 1'b0;
			d_addr_err <= 1'b0;
		end else begin
			reg_wen <= (op == cp0_pkg::OP_MTC0) ? hit : '0;
			d_rsel <= (op == cp0_pkg::OP_MFC0) ? hit : '0;
			d_read <= op == cp0_pkg::OP_MFC0;
			d_tlbp <= op == cp0_pkg::OP_TLBP;
			d_tlbr <= op == cp0_pkg::OP_TLBR;
			d_tlbwi <= op == cp0_pkg::OP_TLBWI;
			d_eret <= op == cp0_pkg::OP_ERET;
			d_exc <= (op == cp0_pkg::OP_EXC) && (|exc_type);
			d_addr_err <= (op == cp0_pkg::OP_EXC) && addr_err;
		end
	end

	always_ff @(posedge clk) begin
		d_wdata <= wdata;
		d_exccode <= exc_code;
		d_pc <= pc;
		d_is_slot <= is_slot;
		d_bad_vaddr <= bad_vaddr;
	end

endmodule

`default_nettype wire

/* hw/cp0_regs.sv */
`default_nettype none

`include "cp0_defines.svh"

module cp0_regs #(
	parameter int tlb_num = `CP0_TLB_NUM
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire [`CP0_NREGS-1:0]        reg_wen,
	input  wire [`CP0_NREGS-1:0]        d_rsel,
	input  wire [31:0]                  d_wdata,
	input  wire                         d_read,
	input  wire                         d_tlbp,
	input  wire                         d_tlbr,
	input  wire                         d_tlbwi,
	input  wire                         d_eret,
	input  wire                         d_exc,
	input  wire cp0_pkg::exc_code_e     d_exccode,
	input  wire                         d_addr_err,
	input  wire [31:0]                  d_pc,
	input  wire                         d_is_slot,
	input  wire [31:0]                  d_bad_vaddr,
	input  wire [5:0]                   int_num,
	input  wire [31:0]                  probe_result,
	input  wire [`CP0_TLB_ENTRY_W-1:0]  rd_entry,
	output logic [31:0]                 rdata,
	output logic                        rdata_valid,
	output logic [31:0]                 epc,
	output logic                        int_happen,
	output logic [18:0]                 probe_vpn2,
	output logic [7:0]                  probe_asid,
	output logic [$clog2(tlb_num)-1:0]  tlb_index,
	output logic [`CP0_TLB_ENTRY_W-1:0] wr_entry,
	output logic                        tlb_wen
);

	localparam int idx_w = $clog2(tlb_num);

	logic [7:0]         status_im;
	logic               status_exl;
	logic               status_ie;
	logic               cause_bd;
	logic               cause_ti;
	logic [5:0]         cause_ip_hw;
	logic [1:0]         cause_ip_sw;
	cp0_pkg::exc_code_e cause_exccode;
	logic [31:0]        badvaddr;
	logic [32:0]        count;
	logic [31:0]        compare;
	logic               index_p;
	logic [idx_w-1:0]   index_val;
	logic [18:0]        entryhi_vpn2;
	logic [7:0]         entryhi_asid;
	logic [29:0]        entrylo0;
	logic [29:0]        entrylo1;
	logic [31:0]        status_rd;
	logic [31:0]        cause_rd;
	logic [31:0]        index_rd;
	logic [31:0]        rd_mux;
	logic               epc_capture;

	// EPC and BD only follow the first exception
	assign epc_capture = d_exc && !status_exl;

	assign status_rd = {9'h0, 1'b1, 6'h0, status_im, 6'h0, status_exl, status_ie};
	assign cause_rd = {cause_bd, cause_ti, 14'h0, cause_ip_hw, cause_ip_sw, 1'b0,
		cause_exccode, 2'b00};
	assign index_rd = {index_p, {(31 - idx_w){1'b0}}, index_val};

	always_ff @(posedge clk) begin
		if (rst) begin
			status_im <= 8'h0;
			status_ie <= 1'b0;
		end else if (reg_wen[`CP0_R_STATUS]) begin
			status_im <= d_wdata[15:8];
			status_ie <= d_wdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status_exl <= 1'b0;
		end else if (d_exc) begin
			status_exl <= 1'b1;
		end else if (d_eret) begin
			status_exl <= 1'b0;
		end else if (reg_wen[`CP0_R_STATUS]) begin
			status_exl <= d_wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_bd <= 1'b0;
			cause_exccode <= cp0_pkg::EXC_INT;
		end else if (d_exc) begin
			cause_exccode <= d_exccode;
			if (epc_capture) begin
				cause_bd <= d_is_slot;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause_ti <= 1'b0;
		end else if (reg_wen[`CP0_R_COMPARE]) begin
			cause_ti <= 1'b0;
		end else if (count[32:1] == compare) begin
			cause_ti <= 1'b1;
		end
	end

	// IP7 shares the timer interrupt
	always_ff @(posedge clk) begin
		if (rst) begin
			cause_ip_hw <= 6'h0;
			cause_ip_sw <= 2'b00;
		end else begin
			cause_ip_hw <= {int_num[5] | cause_ti, int_num[4:0]};
			if (reg_wen[`CP0_R_CAUSE]) begin
				cause_ip_sw <= d_wdata[9:8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (epc_capture) begin
			epc <= d_is_slot ? d_pc - 32'd4 : d_pc;
		end else if (reg_wen[`CP0_R_EPC]) begin
			epc <= d_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (d_exc && d_addr_err) begin
			badvaddr <= d_bad_vaddr;
		end
	end

	// count[0] halves the tick rate
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= 33'h0;
		end else if (reg_wen[`CP0_R_COUNT]) begin
			count <= {d_wdata, 1'b0};
		end else begin
			count <= count + 33'd1;
		end
	end

	// compare starts far from count so no match right after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			compare <= 32'hffff_ffff;
		end else if (reg_wen[`CP0_R_COMPARE]) begin
			compare <= d_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			index_p <= 1'b0;
			index_val <= '0;
		end else if (d_tlbp) begin
			index_p <= probe_result[31];
			index_val <= probe_result[idx_w-1:0];
		end else if (reg_wen[`CP0_R_INDEX]) begin
			index_val <= d_wdata[idx_w-1:0];
		end
	end

	// tlbr refills EntryHi and both EntryLo, G goes to both
	always_ff @(posedge clk) begin
		if (d_tlbr) begin
			entryhi_vpn2 <= rd_entry[77:59];
			entryhi_asid <= rd_entry[58:51];
			entrylo0 <= {4'h0, rd_entry[49:25], rd_entry[50]};
			entrylo1 <= {4'h0, rd_entry[24:0], rd_entry[50]};
		end else begin
			if (reg_wen[`CP0_R_ENTRYHI]) begin
				entryhi_vpn2 <= d_wdata[31:13];
				entryhi_asid <= d_wdata[7:0];
			end
			if (reg_wen[`CP0_R_ENTRYLO0]) begin
				entrylo0 <= d_wdata[29:0];
			end
			if (reg_wen[`CP0_R_ENTRYLO1]) begin
				entrylo1 <= d_wdata[29:0];
			end
		end
	end

	always_comb begin
		rd_mux = {32{d_rsel[`CP0_R_INDEX]}} & index_rd;
		rd_mux |= {32{d_rsel[`CP0_R_ENTRYLO0]}} & {2'b00, entrylo0};
		rd_mux |= {32{d_rsel[`CP0_R_ENTRYLO1]}} & {2'b00, entrylo1};
		rd_mux |= {32{d_rsel[`CP0_R_BADVADDR]}} & badvaddr;
		rd_mux |= {32{d_rsel[`CP0_R_COUNT]}} & count[32:1];
		rd_mux |= {32{d_rsel[`CP0_R_ENTRYHI]}} & {entryhi_vpn2, 5'h0, entryhi_asid};
		rd_mux |= {32{d_rsel[`CP0_R_COMPARE]}} & compare;
		rd_mux |= {32{d_rsel[`CP0_R_STATUS]}} & status_rd;
		rd_mux |= {32{d_rsel[`CP0_R_CAUSE]}} & cause_rd;
		rd_mux |= {32{d_rsel[`CP0_R_EPC]}} & epc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= d_read;
		end
	end

	always_ff @(posedge clk) begin
		if (d_read) begin
			rdata <= rd_mux;
		end
	end

	assign int_happen = !status_exl && status_ie &&
		(|(status_im & {cause_ip_hw, cause_ip_sw}));

	assign probe_vpn2 = entryhi_vpn2;
	assign probe_asid = entryhi_asid;
	assign tlb_index = index_val;
	assign wr_entry = {entryhi_vpn2, entryhi_asid, entrylo0[0] & entrylo1[0],
		entrylo0[25:1], entrylo1[25:1]};
	assign tlb_wen = d_tlbwi;

endmodule

`default_nettype wire

/* hw/tlb_array.sv */
`default_nettype none

`include "cp0_defines.svh"

module tlb_array #(
	parameter int tlb_num = `CP0_TLB_NUM
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire [18:0]                  probe_vpn2,
	input  wire [7:0]                   probe_asid,
	input  wire [$clog2(tlb_num)-1:0]   tlb_index,
	input  wire                         tlb_wen,
	input  wire [`CP0_TLB_ENTRY_W-1:0]  wr_entry,
	output logic [31:0]                 probe_result,
	output logic [`CP0_TLB_ENTRY_W-1:0] rd_entry
);

	localparam int idx_w = $clog2(tlb_num);

	logic [`CP0_TLB_ENTRY_W-1:0] entries [tlb_num];
	logic [tlb_num-1:0]          valid;
	logic [tlb_num-1:0]          match;
	logic                        hit;
	logic [idx_w-1:0]            hit_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (tlb_wen) begin
			valid[tlb_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tlb_wen) begin
			entries[tlb_index] <= wr_entry;
		end
	end

	// vpn2 must match, asid only when not global
	always_comb begin
		for (int i = 0; i < tlb_num; i++) begin
			match[i] = valid[i] && (entries[i][77:59] == probe_vpn2) &&
				(entries[i][50] || (entries[i][58:51] == probe_asid));
		end
	end

	// scan downward so the lowest index is the one kept
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = tlb_num - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit = 1'b1;
				hit_idx = idx_w'(i);
			end
		end
	end

	assign probe_result = {~hit, {(31 - idx_w){1'b0}}, hit_idx};
	assign rd_entry = entries[tlb_index];

endmodule

`default_nettype wire

/* hw/cp0_unit.sv */
`default_nettype none

`include "cp0_defines.svh"

module cp0_unit #(
	parameter int tlb_num = `CP0_TLB_NUM
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire cp0_pkg::cp0_op_e op,
	input  wire [7:0]             reg_addr,
	input  wire [31:0]            wdata,
	input  wire [7:0]             exc_type,
	input  wire [31:0]            pc,
	input  wire                   is_slot,
	input  wire [31:0]            bad_vaddr,
	input  wire [5:0]             int_num,
	output wire [31:0]            rdata,
	output wire                   rdata_valid,
	output wire [31:0]            epc,
	output wire                   int_happen
);

	wire [`CP0_NREGS-1:0]        reg_wen;
	wire [`CP0_NREGS-1:0]        d_rsel;
	wire [31:0]                  d_wdata;
	wire                         d_read;
	wire                         d_tlbp;
	wire                         d_tlbr;
	wire                         d_tlbwi;
	wire                         d_eret;
	wire                         d_exc;
	wire cp0_pkg::exc_code_e     d_exccode;
	wire                         d_addr_err;
	wire [31:0]                  d_pc;
	wire                         d_is_slot;
	wire [31:0]                  d_bad_vaddr;
	wire [18:0]                  probe_vpn2;
	wire [7:0]                   probe_asid;
	wire [$clog2(tlb_num)-1:0]   tlb_index;
	wire [`CP0_TLB_ENTRY_W-1:0]  wr_entry;
	wire                         tlb_wen;
	wire [31:0]                  probe_result;
	wire [`CP0_TLB_ENTRY_W-1:0]  rd_entry;

	cp0_op_decode cp0_op_decode_inst (
		.clk(clk), .rst(rst), .op(op), .reg_addr(reg_addr), .wdata(wdata),
		.exc_type(exc_type), .pc(pc), .is_slot(is_slot), .bad_vaddr(bad_vaddr),
		.reg_wen(reg_wen), .d_rsel(d_rsel), .d_wdata(d_wdata), .d_read(d_read),
		.d_tlbp(d_tlbp), .d_tlbr(d_tlbr), .d_tlbwi(d_tlbwi), .d_eret(d_eret),
		.d_exc(d_exc), .d_exccode(d_exccode), .d_addr_err(d_addr_err),
		.d_pc(d_pc), .d_is_slot(d_is_slot), .d_bad_vaddr(d_bad_vaddr)
	);

	cp0_regs #(.tlb_num(tlb_num)) cp0_regs_inst (
		.clk(clk), .rst(rst), .reg_wen(reg_wen), .d_rsel(d_rsel), .d_wdata(d_wdata),
		.d_read(d_read), .d_tlbp(d_tlbp), .d_tlbr(d_tlbr), .d_tlbwi(d_tlbwi),
		.d_eret(d_eret), .d_exc(d_exc), .d_exccode(d_exccode),
		.d_addr_err(d_addr_err), .d_pc(d_pc), .d_is_slot(d_is_slot),
		.d_bad_vaddr(d_bad_vaddr), .int_num(int_num), .probe_result(probe_result),
		.rd_entry(rd_entry), .rdata(rdata), .rdata_valid(rdata_valid), .epc(epc),
		.int_happen(int_happen), .probe_vpn2(probe_vpn2), .probe_asid(probe_asid),
		.tlb_index(tlb_index), .wr_entry(wr_entry), .tlb_wen(tlb_wen)
	);

	tlb_array #(.tlb_num(tlb_num)) tlb_array_inst (
		.clk(clk), .rst(rst), .probe_vpn2(probe_vpn2), .probe_asid(probe_asid),
		.tlb_index(tlb_index), .tlb_wen(tlb_wen), .wr_entry(wr_entry),
		.probe_result(probe_result), .rd_entry(rd_entry)
	);

endmodule

`default_nettype wire

/* tb/cp0_unit_tb.sv */
`default_nettype none

`include "cp0_defines.svh"

module cp0_unit_tb;

	localparam int max_rows = 256;
	localparam logic [1:0] chk_none = 2'd0;
	localparam logic [1:0] chk_rdata = 2'd1;
	localparam logic [1:0] chk_epc = 2'd2;
	localparam logic [1:0] chk_int = 2'd3;

	logic             clk;
	logic             rst;
	cp0_pkg::cp0_op_e op;
	logic [7:0]       reg_addr;
	logic [31:0]      wdata;
	logic [7:0]       exc_type;
	logic [31:0]      pc;
	logic             is_slot;
	logic [31:0]      bad_vaddr;
	logic [5:0]       int_num;
	wire [31:0]       rdata;
	wire              rdata_valid;
	wire [31:0]       epc;
	wire              int_happen;

	// rows are checked two falling edges after they are driven
	cp0_pkg::cp0_op_e t_op [max_rows];
	logic [7:0]       t_addr [max_rows];
	logic [31:0]      t_wdata [max_rows];
	logic [7:0]       t_exc [max_rows];
	logic [31:0]      t_pc [max_rows];
	logic             t_slot [max_rows];
	logic [31:0]      t_bad [max_rows];
	logic [5:0]       t_int [max_rows];
	logic [1:0]       t_chk [max_rows];
	logic [31:0]      t_exp [max_rows];
	int               n_rows = 0;

	// reference state kept while the table is built
	logic [31:0] rng;
	logic [5:0]  cur_int;
	logic [7:0]  m_im = 8'h0;
	logic        m_exl = 1'b0;
	logic        m_ie = 1'b0;
	logic        m_bd = 1'b0;
	logic [4:0]  m_code = 5'h0;
	logic [1:0]  m_ip_sw = 2'b00;
	logic [31:0] m_epc = 32'h0;
	logic [31:0] m_bad = 32'h0;
	int          cycles = 0;
	int          limit = 0;

	cp0_unit cp0_unit_inst (
		.clk(clk), .rst(rst), .op(op), .reg_addr(reg_addr), .wdata(wdata),
		.exc_type(exc_type), .pc(pc), .is_slot(is_slot), .bad_vaddr(bad_vaddr),
		.int_num(int_num), .rdata(rdata), .rdata_valid(rdata_valid), .epc(epc),
		.int_happen(int_happen)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Checks failed");
			$fatal(1, "timeout, the table did not finish within %0d cycles", limit);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// returns {loads badvaddr, exccode} with the highest priority flag first
	function automatic logic [5:0] exc_priority(input logic [7:0] f);
		if (f[7]) return {1'b0, cp0_pkg::EXC_INT};
		if (f[6]) return {1'b1, cp0_pkg::EXC_ADEL};
		if (f[1]) return {1'b0, cp0_pkg::EXC_RI};
		if (f[3]) return {1'b0, cp0_pkg::EXC_SYS};
		if (f[2]) return {1'b0, cp0_pkg::EXC_BP};
		if (f[0]) return {1'b0, cp0_pkg::EXC_OV};
		if (f[5]) return {1'b1, cp0_pkg::EXC_ADEL};
		return {1'b1, cp0_pkg::EXC_ADES};
	endfunction

	function automatic logic [31:0] status_word();
		return {9'h0, 1'b1, 6'h0, m_im, 6'h0, m_exl, m_ie};
	endfunction

	// IP7 follows TI alone while the hw lines are idle
	function automatic logic [31:0] cause_word(input logic ti);
		return {m_bd, ti, 14'h0, ti, 5'h0, m_ip_sw, 1'b0, m_code, 2'b00};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s expected %h, got %h",
				$time, what, exp, got);
			$display("Checks failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic push_row(input cp0_pkg::cp0_op_e o, input logic [7:0] a,
		input logic [31:0] d, input logic [7:0] f, input logic [31:0] p, input logic s,
		input logic [31:0] b, input logic [1:0] c, input logic [31:0] e);
		t_op[n_rows] = o;
		t_addr[n_rows] = a;
		t_wdata[n_rows] = d;
		t_exc[n_rows] = f;
		t_pc[n_rows] = p;
		t_slot[n_rows] = s;
		t_bad[n_rows] = b;
		t_int[n_rows] = cur_int;
		t_chk[n_rows] = c;
		t_exp[n_rows] = e;
		n_rows++;
	endtask

	task automatic write_reg(input logic [4:0] num, input logic [31:0] d);
		push_row(cp0_pkg::OP_MTC0, {num, 3'd0}, d, 8'h0, 32'h0, 1'b0, 32'h0, chk_none, 32'h0);
		if (num == `CP0_STATUS_NUM) begin
			m_im = d[15:8];
			m_exl = d[1];
			m_ie = d[0];
		end
		if (num == `CP0_CAUSE_NUM) begin
			m_ip_sw = d[9:8];
		end
	endtask

	task automatic read_raw(input logic [7:0] a, input logic [31:0] e);
		push_row(cp0_pkg::OP_MFC0, a, 32'h0, 8'h0, 32'h0, 1'b0, 32'h0, chk_rdata, e);
	endtask

	task automatic read_reg(input logic [4:0] num, input logic [31:0] e);
		read_raw({num, 3'd0}, e);
	endtask

	task automatic write_readback(input logic [4:0] num, input logic [31:0] mask);
		logic [31:0] w;
		w = rand32();
		write_reg(num, w);
		if (num == `CP0_STATUS_NUM) begin
			read_reg(num, status_word());
		end else if (num == `CP0_CAUSE_NUM) begin
			read_reg(num, cause_word(1'b0));
		end else begin
			read_reg(num, w & mask);
		end
	endtask

	task automatic simple_op(input cp0_pkg::cp0_op_e o);
		push_row(o, 8'h0, 32'h0, 8'h0, 32'h0, 1'b0, 32'h0, chk_none, 32'h0);
		if (o == cp0_pkg::OP_ERET) begin
			m_exl = 1'b0;
		end
	endtask

	task automatic idle_rows(input int n);
		repeat (n) simple_op(cp0_pkg::OP_NONE);
	endtask

	task automatic expect_int(input logic v);
		push_row(cp0_pkg::OP_NONE, 8'h0, 32'h0, 8'h0, 32'h0, 1'b0, 32'h0, chk_int, {31'h0, v});
	endtask

	// epc only follows the first exception of a nest
	task automatic report_exc(input logic [7:0] f, input logic [31:0] p, input logic s,
		input logic [31:0] b);
		logic [5:0] pr;
		pr = exc_priority(f);
		if (!m_exl) begin
			m_epc = s ? p - 32'd4 : p;
			m_bd = s;
		end
		m_exl = 1'b1;
		m_code = pr[4:0];
		if (pr[5]) begin
			m_bad = b;
		end
		push_row(cp0_pkg::OP_EXC, 8'h0, 32'h0, f, p, s, b, chk_epc, m_epc);
	endtask

	task automatic build_table();
		logic [31:0] p;
		logic [31:0] hi1;
		logic [31:0] hi2;
		logic [31:0] lo0;
		logic [31:0] lo1;
		logic [7:0]  pairs [7];
		pairs = '{8'h10, 8'h28, 8'h50, 8'h06, 8'h81, 8'h05, 8'h30};
		rng = 32'd57934;
		cur_int = 6'h0;

		// readback of writable fields
		write_readback(`CP0_INDEX_NUM, `CP0_TLB_NUM - 1);
		write_readback(`CP0_ENTRYLO0_NUM, 32'h3fff_ffff);
		write_readback(`CP0_ENTRYLO1_NUM, 32'h3fff_ffff);
		write_readback(`CP0_ENTRYHI_NUM, 32'hffff_e0ff);
		write_readback(`CP0_COUNT_NUM, 32'hffff_ffff);
		write_readback(`CP0_COMPARE_NUM, 32'hffff_ffff);
		write_readback(`CP0_STATUS_NUM, 32'h0);
		write_readback(`CP0_CAUSE_NUM, 32'h0);
		write_readback(`CP0_EPC_NUM, 32'hffff_ffff);
		push_row(cp0_pkg::OP_MTC0, {`CP0_STATUS_NUM, 3'd1}, 32'hffff_ffff, 8'h0, 32'h0,
			1'b0, 32'h0, chk_none, 32'h0);
		read_reg(`CP0_STATUS_NUM, status_word());
		read_raw({`CP0_STATUS_NUM, 3'd1}, 32'h0);
		read_raw({5'd5, 3'd0}, 32'h0);
		write_reg(`CP0_COUNT_NUM, 32'h0);
		write_reg(`CP0_COMPARE_NUM, 32'hffff_ffff);
		write_reg(`CP0_CAUSE_NUM, 32'h0);
		write_reg(`CP0_STATUS_NUM, 32'h0);
		read_reg(`CP0_STATUS_NUM, status_word());

		// delay slot capture and a nested exception
		p = rand32() & 32'hffff_fffc;
		report_exc(8'h02, p, 1'b1, rand32());
		read_reg(`CP0_EPC_NUM, m_epc);
		read_reg(`CP0_CAUSE_NUM, cause_word(1'b0));
		read_reg(`CP0_STATUS_NUM, status_word());
		report_exc(8'h08, rand32() & 32'hffff_fffc, 1'b0, rand32());
		read_reg(`CP0_EPC_NUM, m_epc);
		read_reg(`CP0_CAUSE_NUM, cause_word(1'b0));
		simple_op(cp0_pkg::OP_ERET);
		read_reg(`CP0_STATUS_NUM, status_word());

		// priority between flags, starting with a lone store address error
		for (int i = 0; i < 7; i++) begin
			report_exc(pairs[i], rand32() & 32'hffff_fffc, 1'b0, rand32());
			read_reg(`CP0_CAUSE_NUM, cause_word(1'b0));
			read_reg(`CP0_BADVADDR_NUM, m_bad);
			simple_op(cp0_pkg::OP_ERET);
		end

		// tlb write, read back, probe
		hi1 = rand32() & 32'hffff_e0ff;
		lo0 = rand32() & 32'h03ff_fffe;
		lo1 = rand32() & 32'h03ff_fffe;
		write_reg(`CP0_ENTRYHI_NUM, hi1);
		write_reg(`CP0_ENTRYLO0_NUM, lo0);
		write_reg(`CP0_ENTRYLO1_NUM, lo1);
		write_reg(`CP0_INDEX_NUM, 32'd3);
		simple_op(cp0_pkg::OP_TLBWI);
		write_reg(`CP0_ENTRYHI_NUM, 32'h0);
		write_reg(`CP0_ENTRYLO0_NUM, 32'h0);
		write_reg(`CP0_ENTRYLO1_NUM, 32'h0);
		simple_op(cp0_pkg::OP_TLBR);
		read_reg(`CP0_ENTRYHI_NUM, hi1);
		read_reg(`CP0_ENTRYLO0_NUM, lo0);
		read_reg(`CP0_ENTRYLO1_NUM, lo1);
		simple_op(cp0_pkg::OP_TLBP);
		read_reg(`CP0_INDEX_NUM, 32'd3);
		write_reg(`CP0_ENTRYHI_NUM, hi1 ^ 32'h0000_0001);
		simple_op(cp0_pkg::OP_TLBP);
		read_reg(`CP0_INDEX_NUM, 32'h8000_0000);
		hi2 = hi1 ^ 32'h0040_0000;
		write_reg(`CP0_ENTRYHI_NUM, hi2);
		write_reg(`CP0_ENTRYLO0_NUM, lo0 | 32'h1);
		write_reg(`CP0_ENTRYLO1_NUM, lo1 | 32'h1);
		write_reg(`CP0_INDEX_NUM, 32'd5);
		simple_op(cp0_pkg::OP_TLBWI);
		write_reg(`CP0_ENTRYHI_NUM, hi2 ^ 32'h0000_005a);
		simple_op(cp0_pkg::OP_TLBP);
		read_reg(`CP0_INDEX_NUM, 32'd5);
		write_reg(`CP0_ENTRYLO0_NUM, 32'h0);
		simple_op(cp0_pkg::OP_TLBR);
		read_reg(`CP0_ENTRYLO0_NUM, lo0 | 32'h1);

		// hw line 0 through IM2
		write_reg(`CP0_STATUS_NUM, 32'h0000_0401);
		cur_int = 6'h01;
		expect_int(1'b1);
		write_reg(`CP0_STATUS_NUM, 32'h0000_0403);
		expect_int(1'b0);
		write_reg(`CP0_STATUS_NUM, 32'h0000_0401);
		expect_int(1'b1);
		write_reg(`CP0_STATUS_NUM, 32'h0000_0001);
		expect_int(1'b0);
		cur_int = 6'h0;

		// count ticks every second clock
		write_reg(`CP0_COUNT_NUM, 32'd1000);
		idle_rows(2);
		read_reg(`CP0_COUNT_NUM, 32'd1001);
		write_reg(`CP0_COUNT_NUM, 32'd100);
		write_reg(`CP0_COMPARE_NUM, 32'd103);
		read_reg(`CP0_CAUSE_NUM, cause_word(1'b0));
		idle_rows(9);
		read_reg(`CP0_CAUSE_NUM, cause_word(1'b1));
		write_reg(`CP0_COMPARE_NUM, 32'h7fff_ffff);
		idle_rows(1);
		read_reg(`CP0_CAUSE_NUM, cause_word(1'b0));
	endtask

	task automatic drive_row(input int i);
		op = t_op[i];
		reg_addr = t_addr[i];
		wdata = t_wdata[i];
		exc_type = t_exc[i];
		pc = t_pc[i];
		is_slot = t_slot[i];
		bad_vaddr = t_bad[i];
		int_num = t_int[i];
	endtask

	task automatic drive_idle();
		op = cp0_pkg::OP_NONE;
		reg_addr = 8'h0;
		wdata = 32'h0;
		exc_type = 8'h0;
		pc = 32'h0;
		is_slot = 1'b0;
		bad_vaddr = 32'h0;
		int_num = 6'h0;
	endtask

	task automatic check_row(input int i);
		check_value($sformatf("row %0d rdata_valid", i), {31'h0, rdata_valid},
			{31'h0, t_op[i] == cp0_pkg::OP_MFC0});
		case (t_chk[i])
			chk_rdata: check_value($sformatf("row %0d rdata", i), rdata, t_exp[i]);
			chk_epc: check_value($sformatf("row %0d epc", i), epc, t_exp[i]);
			chk_int: check_value($sformatf("row %0d int_happen", i), {31'h0, int_happen},
				t_exp[i]);
			default: ;
		endcase
	endtask

	initial begin
		rst = 1'b1;
		drive_idle();
		build_table();
		limit = n_rows * 4 + 50;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("rdata_valid after reset", {31'h0, rdata_valid}, 32'h0);
		check_value("int_happen after reset", {31'h0, int_happen}, 32'h0);
		// two spare rows let the last reads come back
		for (int n = 0; n < n_rows + 2; n++) begin
			if (n >= 2) begin
				check_row(n - 2);
			end
			if (n < n_rows) begin
				drive_row(n);
			end else begin
				drive_idle();
			end
			@(negedge clk);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* cp0_unit.f */
+incdir+hw
hw/cp0_pkg.sv
hw/cp0_op_decode.sv
hw/cp0_regs.sv
hw/tlb_array.sv
hw/cp0_unit.sv
tb/cp0_unit_tb.sv

/* Bender.yml */
package:
  name: cp0_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/cp0_pkg.sv
      - hw/cp0_op_decode.sv
      - hw/cp0_regs.sv
      - hw/tlb_array.sv
      - hw/cp0_unit.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/cp0_unit_tb.sv
